/* all.f */
common/ahb_pkg.sv
common/apb_pkg.sv
bridge/ahb_slave_front.sv
bridge/apb_sequencer.sv
hw/apb_decoder.sv
alut/alut_regs.sv
hw/apb_subsystem.sv
sim/tb_apb_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AHB to APB subsystem testbench under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_apb_subsystem -f all.f -o tb_apb_subsystem

out=$(./obj_dir/tb_apb_subsystem 2>&1) || true
echo "$out"
if grep -qx "Verification passed" <<< "$out"; then
   exit 0
fi
exit 1

/* sim/tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem;

   localparam logic [31:0] BASE_ADDR   = 32'h00A0_0000;
   localparam int          REGION_BITS = 16;
   localparam int          TIMEOUT     = 40;
   // ALUT byte offsets of KEY and STATUS
   localparam logic [31:0] KEY_OFS     = 32'h20;
   localparam logic [31:0] STATUS_OFS  = 32'h24;

   logic              hclk;
   logic              arst_n;
   logic              hsel;
   logic [31:0]       haddr;
   ahb_pkg::htrans_e  htrans;
   logic              hwrite;
   logic [31:0]       hwdata;
   logic              hready_in;
   logic [31:0]       hrdata;
   logic              hready;
   ahb_pkg::hresp_e   hresp;
   apb_pkg::apb_req_t apb;
   logic [3:0]        mac_psel;
   apb_pkg::apb_rsp_t mac_rsp [4];

   // Driver side state
   logic [31:0] lfsr;
   logic [31:0] alut_shadow [8];
   int          next_stall;
   // Transfer the driver expects on the APB side
   logic [31:0] exp_addr;
   logic        exp_write;
   logic [31:0] exp_wdata;
   // MAC model state
   logic [31:0] mac_mem [4][16];
   int          stall_left [4];
   logic [31:0] setup_wdata;

   apb_subsystem #(
      .NUM_SLAVES(5), .BASE_ADDR(BASE_ADDR), .REGION_BITS(REGION_BITS), .ALUT_ENTRIES(8)
   ) u_apb_subsystem (
      .hclk(hclk), .arst_n(arst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
      .hwrite(hwrite), .hwdata(hwdata), .hready_in(hready_in), .hrdata(hrdata),
      .hready(hready), .hresp(hresp), .apb(apb), .mac_psel(mac_psel), .mac_rsp(mac_rsp)
   );

   // 40 ns clock
   initial begin
      hclk = 1'b0;
      forever #20 hclk = ~hclk;
   end

   // -------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // MAC word address for port 1 to 4
   function automatic logic [31:0] mac_addr(input int port, input logic [3:0] w);
      return BASE_ADDR + 32'(port << REGION_BITS) + {26'b0, w, 2'b00};
   endfunction

   // Power-up contents derived from the full address
   function automatic logic [31:0] fill_word(input int port, input logic [3:0] w);
      return mac_addr(port + 1, w) ^ 32'h5A5A_A5A5;
   endfunction

   // First matching entry sets the hit flag and gives the index
   function automatic logic [31:0] expect_status(input logic [31:0] key);
      for (int i = 0; i < 8; i++) begin
         if (alut_shadow[i] == key) begin
            return 32'h8000_0000 | 32'(i);
         end
      end
      return 32'h0;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "simulation stopped");
      end
   endtask

   task automatic fail_with(input string what);
      $display("error at %0t: %s", $time, what);
      $display("Verification failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge hclk);
   endtask

   // -------------------------------------------------------------------
   // AHB master entered at a falling edge with hready high
   // -------------------------------------------------------------------
   task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
      logic [31:0]     offset;
      int              region;
      logic            mapped;
      logic [3:0]      exp_psel;
      logic [3:0]      seen;
      int              low_cnt;
      int              exp_cnt;
      ahb_pkg::hresp_e exp_resp;
      ahb_pkg::hresp_e last_resp;
      // Expected outcome from the address map
      offset   = addr - BASE_ADDR;
      region   = int'(offset >> REGION_BITS);
      mapped   = (addr >= BASE_ADDR) && (region < 5);
      exp_psel = 4'b0000;
      if (mapped && region > 0) begin
         exp_psel = 4'b0001 << (region - 1);
      end
      exp_resp   = mapped ? ahb_pkg::OKAY : ahb_pkg::ERROR;
      next_stall = int'(rand_bits(2));
      exp_addr   = addr;
      exp_write  = wr;
      exp_wdata  = wdata;
      // Capture, setup and access plus the MAC stall
      exp_cnt    = (exp_psel != 4'b0000) ? 3 + next_stall : 3;
      hsel   = 1'b1;
      haddr  = addr;
      htrans = ahb_pkg::NONSEQ;
      hwrite = wr;
      @(negedge hclk);
      // Data phase
      hsel      = 1'b0;
      htrans    = ahb_pkg::IDLE;
      hwdata    = wdata;
      seen      = 4'b0000;
      low_cnt   = 0;
      last_resp = ahb_pkg::OKAY;
      while (!hready) begin
         seen      = seen | mac_psel;
         last_resp = hresp;
         low_cnt++;
         if (low_cnt > TIMEOUT) begin
            fail_with("hready stayed low past the timeout");
         end
         @(negedge hclk);
      end
      check_eq("hready_low_cycles", low_cnt, exp_cnt);
      check_eq("mac_psel", 32'(seen), 32'(exp_psel));
      // ERROR shows first with hready low, then with hready high
      check_eq("hresp_first", 32'(last_resp), 32'(exp_resp));
      check_eq("hresp", 32'(hresp), 32'(exp_resp));
      rdata = hrdata;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] rd_unused;
      ahb_xfer(addr, 1'b1, data, rd_unused);
   endtask

   task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
      ahb_xfer(addr, 1'b0, 32'h0, data);
   endtask

   // -------------------------------------------------------------------
   // MAC port models
   // -------------------------------------------------------------------
   initial begin
      logic [3:0] w;
      for (int i = 0; i < 4; i++) begin
         mac_rsp[i]    = '0;
         stall_left[i] = 0;
         for (int k = 0; k < 16; k++) begin
            mac_mem[i][k] = fill_word(i, 4'(k));
         end
      end
      forever begin
         @(negedge hclk);
         w = apb.paddr[5:2];
         for (int i = 0; i < 4; i++) begin
            mac_rsp[i] = '0;
            if (mac_psel[i]) begin
               // Address and direction of the AHB transfer from setup to access
               check_eq("paddr", apb.paddr, exp_addr);
               check_eq("pwrite", 32'(apb.pwrite), 32'(exp_write));
            end
            if (mac_psel[i] && !apb.penable) begin
               // Setup takes the stall length chosen by the driver
               stall_left[i] = next_stall;
               setup_wdata   = apb.pwdata;
               if (exp_write) begin
                  check_eq("pwdata", apb.pwdata, exp_wdata);
               end
            end else if (mac_psel[i]) begin
               // Write data must hold through the stall
               check_eq("pwdata_hold", apb.pwdata, setup_wdata);
               if (stall_left[i] > 0) begin
                  stall_left[i] = stall_left[i] - 1;
               end else begin
                  mac_rsp[i].pready = 1'b1;
                  if (apb.pwrite) begin
                     mac_mem[i][w] = apb.pwdata;
                  end else begin
                     mac_rsp[i].prdata = mac_mem[i][w];
                  end
               end
            end
         end
      end
   end

   // -------------------------------------------------------------------
   // Directed tests
   // -------------------------------------------------------------------
   task automatic reset_state();
      check_eq("hready", 32'(hready), 32'd1);
      check_eq("hresp", 32'(hresp), 32'(ahb_pkg::OKAY));
      check_eq("mac_psel", 32'(mac_psel), 32'd0);
      check_eq("penable", 32'(apb.penable), 32'd0);
   endtask

   task automatic alut_access();
      logic [31:0] rd;
      logic [31:0] key;
      for (int i = 0; i < 8; i++) begin
         alut_shadow[i] = rand_bits(32);
         ahb_write(BASE_ADDR + 32'(4 * i), alut_shadow[i]);
      end
      key = rand_bits(32);
      ahb_write(BASE_ADDR + KEY_OFS, key);
      idle_cycles(2);
      for (int i = 0; i < 8; i++) begin
         ahb_read(BASE_ADDR + 32'(4 * i), rd);
         check_eq("alut_entry", rd, alut_shadow[i]);
      end
      ahb_read(BASE_ADDR + KEY_OFS, rd);
      check_eq("alut_key", rd, key);
   endtask

   task automatic alut_lookup();
      logic [31:0] rd;
      logic [31:0] key;
      // Copy entry 5 into entry 2 for two matches
      key = alut_shadow[5];
      ahb_write(BASE_ADDR + 32'h8, key);
      alut_shadow[2] = key;
      ahb_write(BASE_ADDR + KEY_OFS, key);
      ahb_read(BASE_ADDR + STATUS_OFS, rd);
      check_eq("status_hit", rd, expect_status(key));
      // Single match in the last entry
      key = alut_shadow[7];
      ahb_write(BASE_ADDR + KEY_OFS, key);
      ahb_read(BASE_ADDR + STATUS_OFS, rd);
      check_eq("status_last", rd, expect_status(key));
      // Key outside the table
      key = ~(alut_shadow[0] ^ alut_shadow[3]);
      ahb_write(BASE_ADDR + KEY_OFS, key);
      ahb_read(BASE_ADDR + STATUS_OFS, rd);
      check_eq("status_miss", rd, expect_status(key));
   endtask

   task automatic mac_stalls();
      logic [3:0]  w;
      logic [31:0] data;
      logic [31:0] rd;
      for (int p = 1; p <= 4; p++) begin
         for (int k = 0; k < 3; k++) begin
            w    = 4'(rand_bits(3));
            data = rand_bits(32);
            ahb_write(mac_addr(p, w), data);
            idle_cycles(1);
            ahb_read(mac_addr(p, w), rd);
            check_eq("mac_rdata", rd, data);
         end
         // Word 15 keeps its fill value
         ahb_read(mac_addr(p, 4'hF), rd);
         check_eq("mac_fill", rd, fill_word(p - 1, 4'hF));
      end
   endtask

   task automatic unmapped_access();
      logic [31:0] rd;
      // Just past region 4 where the offset aliases ENTRY0
      ahb_write(BASE_ADDR + 32'(5 << REGION_BITS), 32'hDEAD_BEEF);
      ahb_write(32'h0000_1000, 32'h1234_5678);
      ahb_read(32'hFFFF_FFF0, rd);
      idle_cycles(1);
      for (int i = 0; i < 8; i++) begin
         ahb_read(BASE_ADDR + 32'(4 * i), rd);
         check_eq("alut_unchanged", rd, alut_shadow[i]);
      end
   endtask

   task automatic back_to_back();
      logic [31:0] vals [4];
      logic [31:0] rd;
      logic [31:0] ent;
      // No idle cycles between transfers
      for (int p = 0; p < 4; p++) begin
         vals[p] = rand_bits(32);
         ahb_write(mac_addr(p + 1, 4'h9), vals[p]);
      end
      ent = rand_bits(32);
      ahb_write(BASE_ADDR + 32'h4, ent);
      alut_shadow[1] = ent;
      for (int p = 0; p < 4; p++) begin
         ahb_read(mac_addr(p + 1, 4'h9), rd);
         check_eq("b2b_mac_rdata", rd, vals[p]);
      end
      ahb_read(BASE_ADDR + 32'h4, rd);
      check_eq("b2b_alut_entry", rd, ent);
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial begin
      lfsr       = 32'h6711_1573;
      arst_n     = 1'b0;
      hsel       = 1'b0;
      haddr      = '0;
      htrans     = ahb_pkg::IDLE;
      hwrite     = 1'b0;
      hwdata     = '0;
      hready_in  = 1'b1;
      next_stall = 0;
      for (int i = 0; i < 8; i++) begin
         alut_shadow[i] = '0;
      end
      repeat (5) @(negedge hclk);
      arst_n = 1'b1;
      @(negedge hclk);
      reset_state();
      alut_access();
      alut_lookup();
      mac_stalls();
      unmapped_access();
      back_to_back();
      $display("Verification passed");
      $finish;
   end

endmodule

/* hw/apb_subsystem.sv */
`timescale 1ns/1ps

module apb_subsystem #(
   parameter int          NUM_SLAVES   = 5,
   parameter logic [31:0] BASE_ADDR    = 32'h00A0_0000,
   parameter int          REGION_BITS  = 16,
   parameter int          ALUT_ENTRIES = 8
) (
   // AHB-Lite slave port
   input  logic                  hclk,
   input  logic                  arst_n,
   input  logic                  hsel,
   input  logic [31:0]           haddr,
   input  ahb_pkg::htrans_e      htrans,
   input  logic                  hwrite,
   input  logic [31:0]           hwdata,
   input  logic                  hready_in,
   output logic [31:0]           hrdata,
   output logic                  hready,
   output ahb_pkg::hresp_e       hresp,
   // APB master to MAC ports
   output apb_pkg::apb_req_t     apb,
   output logic [NUM_SLAVES-2:0] mac_psel,
   input  apb_pkg::apb_rsp_t     mac_rsp [NUM_SLAVES-1]
);

   // Front end to sequencer
   logic                  req_valid;
   ahb_pkg::ahb_req_t     req;
   logic                  done;
   logic                  err;
   logic [31:0]           rdata;

   // Sequencer to decoder
   logic                  sel_en;
   logic                  unmapped;
   logic [NUM_SLAVES-1:0] psel;
   apb_pkg::apb_rsp_t     bus_rsp;
   apb_pkg::apb_rsp_t     alut_rsp;
   apb_pkg::apb_rsp_t     slv_rsp [NUM_SLAVES];

   // -------------------------------------------------------------------
   // Region map, ALUT first then MAC ports
   // -------------------------------------------------------------------
   assign slv_rsp[0] = alut_rsp;
   for (genvar i = 1; i < NUM_SLAVES; i++) begin : g_mac
      assign slv_rsp[i] = mac_rsp[i-1];
   end
   assign mac_psel = psel[NUM_SLAVES-1:1];

   ahb_slave_front u_ahb_slave_front (
      .hclk(hclk), .arst_n(arst_n), .hsel(hsel), .haddr(haddr),
      .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata), .hready_in(hready_in),
      .done(done), .rdata(rdata), .err(err), .hrdata(hrdata),
      .hready(hready), .hresp(hresp), .req_valid(req_valid), .req(req)
   );

   apb_sequencer u_apb_sequencer (
      .hclk(hclk), .arst_n(arst_n), .req_valid(req_valid), .req(req),
      .rsp(bus_rsp), .unmapped(unmapped), .apb(apb), .sel_en(sel_en),
      .done(done), .rdata(rdata), .err(err)
   );

   apb_decoder #(
      .NUM_SLAVES(NUM_SLAVES), .BASE_ADDR(BASE_ADDR), .REGION_BITS(REGION_BITS)
   ) u_apb_decoder (
      .apb(apb), .sel_en(sel_en), .slv_rsp(slv_rsp),
      .psel(psel), .rsp(bus_rsp), .unmapped(unmapped)
   );

   alut_regs #(
      .ALUT_ENTRIES(ALUT_ENTRIES)
   ) u_alut_regs (
      .hclk(hclk), .arst_n(arst_n), .psel(psel[0]), .apb(apb), .rsp(alut_rsp)
   );

endmodule

/* alut/alut_regs.sv */
`timescale 1ns/1ps

module alut_regs #(
   parameter int ALUT_ENTRIES = 8
) (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              psel,
   input  apb_pkg::apb_req_t apb,
   output apb_pkg::apb_rsp_t rsp
);

   localparam int IDX_W = (ALUT_ENTRIES > 1) ? $clog2(ALUT_ENTRIES) : 1;

   logic [31:0]         entry_q [ALUT_ENTRIES];
   logic [31:0]         key_q;
   apb_pkg::alut_reg_e  word;
   logic                wr_en;
   logic                hit;
   logic [IDX_W-1:0]    hit_idx;
   logic [31:0]         status;

   // Word offset within the 7-bit region offset
   assign word  = apb_pkg::alut_reg_e'(apb.paddr[6:2]);
   // Writes land in the access phase
   assign wr_en = psel && apb.penable && apb.pwrite;

   // -------------------------------------------------------------------
   // Table and key registers
   // -------------------------------------------------------------------
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         key_q <= '0;
         for (int i = 0; i < ALUT_ENTRIES; i++) begin
            entry_q[i] <= '0;
         end
      end else if (wr_en) begin
         if (word == apb_pkg::KEY) key_q <= apb.pwdata;
         // Entries from ENTRY0 upward
         for (int i = 0; i < ALUT_ENTRIES; i++) begin
            if (int'(word) == i) entry_q[i] <= apb.pwdata;
         end
      end
   end

   // -------------------------------------------------------------------
   // Lookup, lowest matching index wins
   // -------------------------------------------------------------------
   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = ALUT_ENTRIES - 1; i >= 0; i--) begin
         if (entry_q[i] == key_q) begin
            hit     = 1'b1;
            hit_idx = IDX_W'(i);
         end
      end
      status              = '0;
      status[31]          = hit;
      status[IDX_W-1:0]   = hit_idx;
   end

   // Read mux, holes read zero
   always_comb begin
      rsp.pready = 1'b1;
      case (word)
         apb_pkg::KEY:    rsp.prdata = key_q;
         apb_pkg::STATUS: rsp.prdata = status;
         default: begin
            if (int'(word) < ALUT_ENTRIES) begin
               rsp.prdata = entry_q[word[IDX_W-1:0]];
            end else begin
               rsp.prdata = '0;
            end
         end
      endcase
   end

endmodule

/* hw/apb_decoder.sv */
`timescale 1ns/1ps

module apb_decoder #(
   parameter int          NUM_SLAVES  = 5,
   parameter logic [31:0] BASE_ADDR   = 32'h00A0_0000,
   parameter int          REGION_BITS = 16
) (
   input  apb_pkg::apb_req_t     apb,
   input  logic                  sel_en,
   input  apb_pkg::apb_rsp_t     slv_rsp [NUM_SLAVES],
   output logic [NUM_SLAVES-1:0] psel,
   output apb_pkg::apb_rsp_t     rsp,
   output logic                  unmapped
);

   // Width of the region index field
   localparam int RW = 32 - REGION_BITS;

   logic [31:0]   offset;
   logic [RW-1:0] region;
   logic          below_base;

   // -------------------------------------------------------------------
   // Region index
   // -------------------------------------------------------------------
   assign offset     = apb.paddr - BASE_ADDR;
   assign region     = offset[31:REGION_BITS];
   assign below_base = (apb.paddr < BASE_ADDR);

   // Below base or past the last region
   assign unmapped = below_base || (region >= RW'(NUM_SLAVES));

   // -------------------------------------------------------------------
   // One-hot select and response mux
   // -------------------------------------------------------------------
   always_comb begin
      psel = '0;
      rsp  = '0;
      for (int i = 0; i < NUM_SLAVES; i++) begin
         if (!unmapped && region == RW'(i)) begin
            // Select only while the sequencer is in a phase
            psel[i] = sel_en;
            rsp     = slv_rsp[i];
         end
      end
   end

endmodule

/* bridge/apb_sequencer.sv */
`timescale 1ns/1ps

module apb_sequencer (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              req_valid,
   input  ahb_pkg::ahb_req_t req,
   input  apb_pkg::apb_rsp_t rsp,
   input  logic              unmapped,
   output apb_pkg::apb_req_t apb,
   output logic              sel_en,
   output logic              done,
   output logic [31:0]       rdata,
   output logic              err
);

   apb_pkg::seq_state_e state;
   apb_pkg::seq_state_e state_nxt;

   // Transfer payload, stable from SETUP to end of ACCESS
   logic [31:0] paddr_q;
   logic        pwrite_q;
   logic [31:0] pwdata_q;

   // -------------------------------------------------------------------
   // State machine
   // -------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         apb_pkg::IDLE: begin
            if (req_valid) state_nxt = apb_pkg::SETUP;
         end
         apb_pkg::SETUP: begin
            // Unmapped ends here, no access phase
            if (unmapped) begin
               state_nxt = apb_pkg::DONE;
            end else begin
               state_nxt = apb_pkg::ACCESS;
            end
         end
         apb_pkg::ACCESS: begin
            // Slave stall stretches this state
            if (rsp.pready) state_nxt = apb_pkg::DONE;
         end
         apb_pkg::DONE: begin
            // Recovery cycle while the AHB side answers
            state_nxt = apb_pkg::IDLE;
         end
         default: state_nxt = apb_pkg::IDLE;
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state <= apb_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Load on request, only from IDLE
   always_ff @(posedge hclk) begin
      if (state == apb_pkg::IDLE && req_valid) begin
         paddr_q  <= req.addr;
         pwrite_q <= req.write;
         pwdata_q <= req.wdata;
      end
   end

   // -------------------------------------------------------------------
   // APB drive and completion
   // -------------------------------------------------------------------
   assign apb.paddr   = paddr_q;
   assign apb.pwrite  = pwrite_q;
   assign apb.pwdata  = pwdata_q;
   assign apb.penable = (state == apb_pkg::ACCESS);

   // psel enable spans setup and access
   assign sel_en = (state == apb_pkg::SETUP) || (state == apb_pkg::ACCESS);

   // Completion in the last cycle of the transfer
   assign err   = (state == apb_pkg::SETUP) && unmapped;
   assign done  = err || ((state == apb_pkg::ACCESS) && rsp.pready);
   assign rdata = rsp.prdata;

endmodule

/* bridge/ahb_slave_front.sv */
`timescale 1ns/1ps

module ahb_slave_front (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              hsel,
   input  logic [31:0]       haddr,
   input  ahb_pkg::htrans_e  htrans,
   input  logic              hwrite,
   input  logic [31:0]       hwdata,
   input  logic              hready_in,
   input  logic              done,
   input  logic [31:0]       rdata,
   input  logic              err,
   output logic [31:0]       hrdata,
   output logic              hready,
   output ahb_pkg::hresp_e   hresp,
   output logic              req_valid,
   output ahb_pkg::ahb_req_t req
);

   logic        accept;
   logic [31:0] addr_q;
   logic        write_q;
   // Second cycle of the ERROR response pending
   logic        err_pend;

   // Valid NONSEQ or SEQ with the bus ready
   assign accept = hsel && hready_in && hready &&
                   (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

   // -------------------------------------------------------------------
   // Address phase capture
   // -------------------------------------------------------------------
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= haddr;
         write_q <= hwrite;
      end
   end

   // hwdata joins in the data phase, the cycle req_valid is high
   assign req.addr  = addr_q;
   assign req.write = write_q;
   assign req.wdata = hwdata;

   // -------------------------------------------------------------------
   // hready / hresp sequencing
   // -------------------------------------------------------------------
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         hready    <= 1'b1;
         hresp     <= ahb_pkg::OKAY;
         req_valid <= 1'b0;
         err_pend  <= 1'b0;
      end else begin
         // One-cycle pulse, lands in the data phase
         req_valid <= accept;
         if (err_pend) begin
            // ERROR second cycle, hresp held
            hready   <= 1'b1;
            err_pend <= 1'b0;
         end else if (done && err) begin
            // ERROR first cycle, hready still low
            hresp    <= ahb_pkg::ERROR;
            err_pend <= 1'b1;
         end else if (done) begin
            hready <= 1'b1;
            hresp  <= ahb_pkg::OKAY;
         end else if (accept) begin
            // Stall the master until completion
            hready <= 1'b0;
            hresp  <= ahb_pkg::OKAY;
         end else if (hready) begin
            hresp <= ahb_pkg::OKAY;
         end
      end
   end

   // Read data held from completion
   always_ff @(posedge hclk) begin
      if (done && !err) begin
         hrdata <= rdata;
      end
   end

endmodule

/* common/apb_pkg.sv */
package apb_pkg;

   // -------------------------------------------------------------------
   // APB bus bundles
   // -------------------------------------------------------------------

   // Master side, shared by every slave
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      logic [31:0] pwdata;
      logic        penable;
   } apb_req_t;

   // Slave side, one per region
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

   // Transfer sequencer states
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      SETUP  = 2'd1,
      ACCESS = 2'd2,
      DONE   = 2'd3
   } seq_state_e;

   // -------------------------------------------------------------------
   // ALUT register map, word offsets in paddr[6:2]
   // -------------------------------------------------------------------
   typedef enum logic [4:0] {
      ENTRY0 = 5'd0,
      ENTRY1 = 5'd1,
      ENTRY2 = 5'd2,
      ENTRY3 = 5'd3,
      ENTRY4 = 5'd4,
      ENTRY5 = 5'd5,
      ENTRY6 = 5'd6,
      ENTRY7 = 5'd7,
      KEY    = 5'd8,
      STATUS = 5'd9
   } alut_reg_e;

endpackage

/* common/ahb_pkg.sv */
package ahb_pkg;

   // -------------------------------------------------------------------
   // AHB-Lite bus encodings
   // -------------------------------------------------------------------

   // Transfer type on htrans
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // Slave response on hresp
   // Only the first two codes exist on AHB-Lite
   typedef enum logic [1:0] {
      OKAY  = 2'b00,
      ERROR = 2'b01
   } hresp_e;

   // -------------------------------------------------------------------
   // Transfer captured by the slave front end
   // -------------------------------------------------------------------
   typedef struct packed {
      logic [31:0] addr;
      logic        write;
      logic [31:0] wdata;
   } ahb_req_t;

endpackage
